//--- filelist.f
+incdir+design
design/pifo_pkg.sv
design/pifo_node_sram.sv
design/pifo_node_merge.sv
design/pifo_level.sv
design/pifo_tree.sv
tests/tb_clock.sv
tests/pifo_tree_checker.sv
tests/tb_pifo_tree.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pifo_tree -f filelist.f > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_pifo_tree >> "$LOG" 2>&1 \
    || echo "Build or simulation ended with an error" >> "$LOG"
cat "$LOG"
grep -q "All tests passed!" "$LOG" && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

//--- tests/tb_pifo_tree.sv
`default_nettype none
`timescale 1ns/1ps

`include "pifo_macros.svh"

module tb_pifo_tree;
    import pifo_pkg::*;

    localparam rank_t EMPTY_RANK = `PIFO_EMPTY_RANK;
    localparam int    CAPACITY   = 30;
    localparam int    WAIT_LIMIT = 20;

    logic  clk;
    logic  arst_n;
    logic  push;
    rank_t push_rank;
    logic  pop;
    logic  ready;
    logic  pop_valid;
    rank_t pop_rank;

    rank_t model_q [$];     // Reference queue, kept ascending
    int    err_cnt;
    int    test_err_base;
    int    tests_passed;
    int    tests_failed;

    tb_clock #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (10)
    ) u_clock (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    pifo_tree u_dut (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .i_push      (push),
        .i_push_rank (push_rank),
        .i_pop       (pop),
        .o_ready     (ready),
        .o_pop_valid (pop_valid),
        .o_pop_rank  (pop_rank)
    );

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    function automatic void model_insert(input rank_t r);
        int idx;
        idx = 0;
        while (idx < model_q.size() && model_q[idx] <= r) begin
            idx++;
        end
        model_q.insert(idx, r);
    endfunction

    function automatic rank_t model_take_min();
        if (model_q.size() == 0) begin
            return EMPTY_RANK;
        end
        return model_q.pop_front();
    endfunction

    function automatic rank_t random_rank();
        return rank_t'($urandom_range(32'hfffe, 0));    // All-ones never pushed
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!ready) begin
            report_timeout("o_ready");
        end
    endtask

    task automatic issue_push(input rank_t r);
        wait_ready();
        push      = 1'b1;
        push_rank = r;
        tick();
        push      = 1'b0;
        model_insert(r);
    endtask

    // Pop one rank and compare it with the model minimum
    task automatic pop_and_check(input string what);
        rank_t expected;
        int    cycles;
        wait_ready();
        pop = 1'b1;
        tick();
        pop    = 1'b0;
        cycles = 0;
        while (!pop_valid && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        if (!pop_valid) begin
            report_timeout("o_pop_valid");
        end
        if (cycles != 0) begin
            $display("Pop result came %0d cycles late at %0t (%s)", cycles, $time, what);
            err_cnt++;
        end
        expected = model_take_min();
        if (pop_rank !== expected) begin
            $display("Mismatch at %0t: %s popped %0d, expected %0d",
                     $time, what, pop_rank, expected);
            err_cnt++;
        end
    endtask

    task automatic drain(input string what);
        while (model_q.size() > 0) begin
            pop_and_check(what);
        end
    endtask

    task automatic start_test();
        test_err_base = err_cnt;
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_err_base) begin
            $display("PASS  %s", name);
            tests_passed++;
        end else begin
            $display("FAIL  %s (%0d errors)", name, err_cnt - test_err_base);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        start_test();
        if (ready !== 1'b1) begin
            $display("Mismatch at %0t: o_ready is %b after reset", $time, ready);
            err_cnt++;
        end
        if (pop_valid !== 1'b0) begin
            $display("Mismatch at %0t: o_pop_valid is %b after reset", $time, pop_valid);
            err_cnt++;
        end
        pop_and_check("empty tree");
        finish_test("reset state and empty pop");
    endtask

    task automatic test_descending();
        start_test();
        for (int i = 0; i < 12; i++) begin
            issue_push(rank_t'(1000 - 37 * i));
        end
        drain("descending");
        finish_test("descending pushes pop ascending");
    endtask

    task automatic test_duplicates();
        rank_t dups [12] = '{16'd7, 16'd3, 16'd7, 16'd12, 16'd3, 16'd3,
                             16'd9, 16'd12, 16'd1, 16'd7, 16'd9, 16'd1};
        start_test();
        foreach (dups[i]) begin
            issue_push(dups[i]);
        end
        drain("duplicates");
        finish_test("duplicate ranks");
    endtask

    task automatic test_random_mix();
        start_test();
        for (int op = 0; op < 80; op++) begin
            if (model_q.size() == 0 ||
                (model_q.size() < CAPACITY && $urandom_range(99, 0) < 55)) begin
                issue_push(random_rank());
            end else begin
                pop_and_check("random mix");
            end
        end
        drain("random mix drain");
        finish_test("random push and pop mix");
    endtask

    task automatic test_ignored_commands();
        start_test();
        issue_push(16'd40);
        issue_push(16'd10);
        issue_push(16'd30);
        issue_push(16'd20);
        // Push and pop together, neither may take effect
        wait_ready();
        push      = 1'b1;
        pop       = 1'b1;
        push_rank = 16'd5;
        tick();
        push = 1'b0;
        pop  = 1'b0;
        if (pop_valid !== 1'b0) begin
            $display("Mismatch at %0t: pop result after push and pop together", $time);
            err_cnt++;
        end
        pop_and_check("before busy pop");
        if (ready !== 1'b0) begin
            $display("Mismatch at %0t: o_ready high in the pop cycle", $time);
            err_cnt++;
        end
        pop = 1'b1;     // Offered while o_ready is low
        tick();
        pop = 1'b0;
        if (pop_valid !== 1'b0) begin
            $display("Mismatch at %0t: pop taken while o_ready was low", $time);
            err_cnt++;
        end
        drain("after ignored commands");
        pop_and_check("empty after ignored commands");
        finish_test("ignored commands");
    endtask

    task automatic test_fill_drain();
        start_test();
        for (int i = 0; i < CAPACITY; i++) begin
            issue_push(random_rank());
        end
        drain("full drain");
        pop_and_check("empty after drain");
        finish_test("fill to capacity and drain");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int cycles;
        push          = 1'b0;
        push_rank     = '0;
        pop           = 1'b0;
        err_cnt       = 0;
        test_err_base = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cycles        = 0;
        void'($urandom(83));

        tick();
        while (!arst_n && cycles < 40) begin
            tick();
            cycles++;
        end
        if (!arst_n) begin
            report_timeout("reset release");
        end
        tick();

        test_reset_state();
        test_descending();
        test_duplicates();
        test_random_mix();
        test_ignored_commands();
        test_fill_drain();

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/pifo_tree_checker.sv
`default_nettype none
`timescale 1ns/1ps

module pifo_tree_checker (
    input logic i_clk,
    input logic i_arst_n,
    input logic i_push,
    input logic i_pop,
    input logic i_ready,
    input logic i_pop_valid
);

    logic pop_accept;

    assign pop_accept = i_ready && i_pop && !i_push;   // Pop taken at this edge

    a_valid_after_pop: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) pop_accept |=> i_pop_valid
    ) else $error("o_pop_valid missing one cycle after an accepted pop");

    a_valid_has_pop: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) i_pop_valid |-> $past(pop_accept)
    ) else $error("o_pop_valid high without an accepted pop");

    a_busy_after_pop: assert property (
        @(posedge i_clk) disable iff (!i_arst_n) pop_accept |=> !i_ready
    ) else $error("o_ready high in the cycle after an accepted pop");

    // Nothing comes out while the tree is held in reset
    a_quiet_in_reset: assert property (
        @(posedge i_clk) !i_arst_n |-> !i_pop_valid
    ) else $error("o_pop_valid high during reset");

endmodule

bind pifo_tree pifo_tree_checker u_checker (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_push      (i_push),
    .i_pop       (i_pop),
    .i_ready     (o_ready),
    .i_pop_valid (o_pop_valid)
);

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            o_clk = ~o_clk;
        end
    end

    // Falling edge just after time zero so every flop sees the reset
    initial begin
        o_arst_n = 1'b1;
        #1;
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_arst_n = 1'b1;    // Released between edges
    end

endmodule

`default_nettype wire

//--- design/pifo_tree.sv
`default_nettype none
`timescale 1ns/1ps

`include "pifo_macros.svh"

module pifo_tree (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_push,
    input  pifo_pkg::rank_t i_push_rank,
    input  logic            i_pop,
    output logic            o_ready,
    output logic            o_pop_valid,
    output pifo_pkg::rank_t o_pop_rank
);
    import pifo_pkg::*;

    // Entry k feeds level k, entry k+1 is driven by level k
    logic                    push_cmd  [`PIFO_LEVELS+1];
    rank_t                   push_rank [`PIFO_LEVELS+1];
    logic                    pop_cmd   [`PIFO_LEVELS+1];
    rank_t                   pop_rank  [`PIFO_LEVELS+1];
    logic [`PIFO_LEVELS-1:0] node_addr [`PIFO_LEVELS+1];
    logic                    level_ready [`PIFO_LEVELS];
    logic                    level_valid [`PIFO_LEVELS];

    assign push_cmd[0]            = i_push;
    assign push_rank[0]           = i_push_rank;
    assign pop_cmd[0]             = i_pop;
    assign node_addr[0]           = '0;               // Single root node
    assign pop_rank[`PIFO_LEVELS] = `PIFO_EMPTY_RANK; // Nothing below the last level

    assign o_ready     = level_ready[0];
    assign o_pop_valid = level_valid[0];
    assign o_pop_rank  = pop_rank[0];

    // ------------------------------------------------------------------------
    // One engine and one node memory per level
    // ------------------------------------------------------------------------
    for (genvar lvl = 0; lvl < `PIFO_LEVELS; lvl++) begin : g_level
        localparam int ADDR_W       = (lvl > 0) ? lvl : 1;
        localparam int CHILD_ADDR_W = lvl + 1;

        logic                    rd_en;
        logic [ADDR_W-1:0]       rd_addr;
        node_word_t              rd_word;
        logic                    wr_en;
        logic [ADDR_W-1:0]       wr_addr;
        node_word_t              wr_word;
        logic [CHILD_ADDR_W-1:0] child_addr;

        pifo_level #(
            .LEVEL_IDX (lvl)
        ) u_level (
            .i_clk            (i_clk),
            .i_arst_n         (i_arst_n),
            .i_push           (push_cmd[lvl]),
            .i_push_rank      (push_rank[lvl]),
            .i_pop            (pop_cmd[lvl]),
            .i_addr           (node_addr[lvl][ADDR_W-1:0]),
            .i_rd_word        (rd_word),
            .i_child_pop_rank (pop_rank[lvl+1]),
            .o_ready          (level_ready[lvl]),
            .o_pop_valid      (level_valid[lvl]),
            .o_pop_rank       (pop_rank[lvl]),
            .o_rd_en          (rd_en),
            .o_rd_addr        (rd_addr),
            .o_wr_en          (wr_en),
            .o_wr_addr        (wr_addr),
            .o_wr_word        (wr_word),
            .o_child_push     (push_cmd[lvl+1]),
            .o_child_rank     (push_rank[lvl+1]),
            .o_child_pop      (pop_cmd[lvl+1]),
            .o_child_addr     (child_addr)
        );

        assign node_addr[lvl+1] = `PIFO_LEVELS'(child_addr);   // Zero-extended

        pifo_node_sram #(
            .ADDR_W (ADDR_W)
        ) u_sram (
            .i_clk     (i_clk),
            .i_arst_n  (i_arst_n),
            .i_rd_en   (rd_en),
            .i_rd_addr (rd_addr),
            .o_rd_word (rd_word),
            .i_wr_en   (wr_en),
            .i_wr_addr (wr_addr),
            .i_wr_word (wr_word)
        );
    end

endmodule

`default_nettype wire

//--- design/pifo_level.sv
`default_nettype none
`timescale 1ns/1ps

`include "pifo_macros.svh"

module pifo_level #(
    parameter  int LEVEL_IDX    = 0,
    localparam int ADDR_W       = (LEVEL_IDX > 0) ? LEVEL_IDX : 1,
    localparam int CHILD_ADDR_W = LEVEL_IDX + 1
) (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_push,
    input  pifo_pkg::rank_t         i_push_rank,
    input  logic                    i_pop,
    input  logic [ADDR_W-1:0]       i_addr,
    input  pifo_pkg::node_word_t    i_rd_word,
    input  pifo_pkg::rank_t         i_child_pop_rank,
    output logic                    o_ready,
    output logic                    o_pop_valid,
    output pifo_pkg::rank_t         o_pop_rank,
    output logic                    o_rd_en,
    output logic [ADDR_W-1:0]       o_rd_addr,
    output logic                    o_wr_en,
    output logic [ADDR_W-1:0]       o_wr_addr,
    output pifo_pkg::node_word_t    o_wr_word,
    output logic                    o_child_push,
    output pifo_pkg::rank_t         o_child_rank,
    output logic                    o_child_pop,
    output logic [CHILD_ADDR_W-1:0] o_child_addr
);
    import pifo_pkg::*;

    localparam logic HAS_CHILD = (LEVEL_IDX < `PIFO_LEVELS - 1);

    level_state_e      state;
    level_state_e      state_nxt;
    logic              accept;
    rank_t             push_rank_q;
    logic [ADDR_W-1:0] addr_q;
    rank_t             min_rank;
    logic              child_push;
    logic              child_pop;

    // ------------------------------------------------------------------------
    // Command acceptance and state machine
    // ------------------------------------------------------------------------
    assign accept = (state != ST_POP) && (i_push ^ i_pop);  // Both high is dropped

    always_comb begin
        if (accept) begin
            state_nxt = i_push ? ST_PUSH : ST_POP;
        end else if (state == ST_POP) begin
            state_nxt = ST_WB;
        end else begin
            state_nxt = ST_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            push_rank_q <= i_push_rank;
            addr_q      <= i_addr;
        end
    end

    pifo_node_merge #(
        .ADDR_W       (ADDR_W),
        .CHILD_ADDR_W (CHILD_ADDR_W)
    ) u_merge (
        .i_mode_push      (state == ST_PUSH),
        .i_mode_pop       ((state == ST_POP) || (state == ST_WB)),
        .i_word           (i_rd_word),
        .i_push_rank      (push_rank_q),
        .i_child_pop_rank (i_child_pop_rank),
        .i_addr           (addr_q),
        .o_wr_word        (o_wr_word),
        .o_min_rank       (min_rank),
        .o_child_push     (child_push),
        .o_child_rank     (o_child_rank),
        .o_child_pop      (child_pop),
        .o_child_addr     (o_child_addr)
    );

    assign o_ready     = (state != ST_POP);
    assign o_pop_valid = (state == ST_POP);
    assign o_pop_rank  = min_rank;

    assign o_rd_en   = accept;      // Word is back in the next state
    assign o_rd_addr = i_addr;
    assign o_wr_en   = (state == ST_PUSH) || (state == ST_WB);
    assign o_wr_addr = addr_q;

    // Child pop once per pop, nothing below the last level
    assign o_child_push = HAS_CHILD && child_push;
    assign o_child_pop  = HAS_CHILD && child_pop && (state == ST_POP);

endmodule

`default_nettype wire

//--- design/pifo_node_merge.sv
`default_nettype none
`timescale 1ns/1ps

`include "pifo_macros.svh"

module pifo_node_merge #(
    parameter int ADDR_W       = 1,
    parameter int CHILD_ADDR_W = 2
) (
    input  logic                    i_mode_push,
    input  logic                    i_mode_pop,
    input  pifo_pkg::node_word_t    i_word,
    input  pifo_pkg::rank_t         i_push_rank,
    input  pifo_pkg::rank_t         i_child_pop_rank,
    input  logic [ADDR_W-1:0]       i_addr,
    output pifo_pkg::node_word_t    o_wr_word,
    output pifo_pkg::rank_t         o_min_rank,
    output logic                    o_child_push,
    output pifo_pkg::rank_t         o_child_rank,
    output logic                    o_child_pop,
    output logic [CHILD_ADDR_W-1:0] o_child_addr
);
    import pifo_pkg::*;

    localparam rank_t EMPTY_RANK = `PIFO_EMPTY_RANK;

    rank_t         rank0;
    rank_t         rank1;
    count_t        cnt0;
    count_t        cnt1;
    logic          push_slot;
    logic          pop_slot;
    logic          slot;
    rank_t         slot_rank;
    count_t        slot_cnt;
    rank_t         new_rank;
    count_t        new_cnt;
    logic [ADDR_W:0] child_full;

    assign {cnt1, rank1, cnt0, rank0} = i_word;

    // ------------------------------------------------------------------------
    // Slot selection
    // ------------------------------------------------------------------------
    assign push_slot = (cnt1 < cnt0);     // Lighter sub-tree, ties to slot 0
    assign pop_slot  = (rank1 < rank0);   // Smaller rank, ties to slot 0
    assign slot      = i_mode_pop ? pop_slot : push_slot;

    assign slot_rank = slot ? rank1 : rank0;
    assign slot_cnt  = slot ? cnt1 : cnt0;

    assign o_min_rank = pop_slot ? rank1 : rank0;

    // ------------------------------------------------------------------------
    // Slot update and child command
    // ------------------------------------------------------------------------
    always_comb begin
        new_rank     = slot_rank;
        new_cnt      = slot_cnt;
        o_child_push = 1'b0;
        o_child_rank = '0;
        o_child_pop  = 1'b0;

        if (i_mode_push) begin
            new_cnt = slot_cnt + count_t'(1);
            if (slot_rank == EMPTY_RANK) begin
                new_rank = i_push_rank;           // Free slot absorbs the rank
            end else begin
                o_child_push = 1'b1;
                if (i_push_rank < slot_rank) begin
                    new_rank     = i_push_rank;
                    o_child_rank = slot_rank;     // Displaced rank goes down
                end else begin
                    o_child_rank = i_push_rank;
                end
            end
        end else if (i_mode_pop) begin
            o_child_pop = 1'b1;
            new_rank    = i_child_pop_rank;       // Refill from the sub-tree
            if (slot_cnt != '0) begin
                new_cnt = slot_cnt - count_t'(1);
            end
        end
    end

    always_comb begin
        if (slot) begin
            o_wr_word = {new_cnt, new_rank, cnt0, rank0};
        end else begin
            o_wr_word = {cnt1, rank1, new_cnt, new_rank};
        end
    end

    // Child node sits at twice this address plus the slot
    assign child_full   = {i_addr, slot};
    assign o_child_addr = child_full[CHILD_ADDR_W-1:0];

endmodule

`default_nettype wire

//--- design/pifo_node_sram.sv
`default_nettype none
`timescale 1ns/1ps

`include "pifo_macros.svh"

module pifo_node_sram #(
    parameter int ADDR_W = 1
) (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic                 i_rd_en,
    input  logic [ADDR_W-1:0]    i_rd_addr,
    output pifo_pkg::node_word_t o_rd_word,
    input  logic                 i_wr_en,
    input  logic [ADDR_W-1:0]    i_wr_addr,
    input  pifo_pkg::node_word_t i_wr_word
);
    import pifo_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;
    localparam rank_t EMPTY_RANK = `PIFO_EMPTY_RANK;
    localparam node_word_t EMPTY_WORD = {count_t'(0), EMPTY_RANK, count_t'(0), EMPTY_RANK};

    node_word_t       mem [DEPTH];
    logic [DEPTH-1:0] word_valid;     // Word written since reset

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            word_valid <= '0;
        end else if (i_wr_en) begin
            word_valid[i_wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_word;
        end
    end

    // Registered read, write-first on an address match
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            if (i_wr_en && (i_wr_addr == i_rd_addr)) begin
                o_rd_word <= i_wr_word;
            end else if (word_valid[i_rd_addr]) begin
                o_rd_word <= mem[i_rd_addr];
            end else begin
                o_rd_word <= EMPTY_WORD;  // Never written, two empty slots
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pifo_pkg.sv
`default_nettype none

`include "pifo_macros.svh"

package pifo_pkg;

    // One scheduling rank
    typedef logic [`PIFO_RANK_W-1:0] rank_t;

    // Entries held in a slot plus everything below it
    typedef logic [`PIFO_CNT_W-1:0] count_t;

    // Node word layout {cnt1, rank1, cnt0, rank0}
    typedef logic [2*(`PIFO_CNT_W+`PIFO_RANK_W)-1:0] node_word_t;

    // Level engine states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_PUSH = 2'b01,
        ST_POP  = 2'b11,
        ST_WB   = 2'b10   // Commit rank returned by the child
    } level_state_e;

endpackage

`default_nettype wire

//--- design/pifo_macros.svh
`ifndef PIFO_MACROS_SVH
`define PIFO_MACROS_SVH

// ---------------------------------------------------------------------------
// Tree sizing
// ---------------------------------------------------------------------------

// Rank datapath width
`define PIFO_RANK_W 16

// Per-slot sub-tree entry counter
`define PIFO_CNT_W 10

// Number of tree levels, capacity is 2 + 4 + 8 + 16 entries
`define PIFO_LEVELS 4

// All-ones rank marks an unused slot
`define PIFO_EMPTY_RANK {`PIFO_RANK_W{1'b1}}

`endif
